// File: hw/isaPkg.sv
package isaPkg;

   ////////////////////////////////////////
   // instruction fields
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      opAdd  = 3'd0, // operand + acc
      opSub  = 3'd1, // operand - acc
      opAnd  = 3'd2,
      opOr   = 3'd3,
      opMov  = 3'd4, // pass operand
      opShl  = 3'd5,
      opShr  = 3'd6,
      opNone = 3'd7  // result forced to zero
   } opcodeT;

   typedef enum logic {
      srcImm = 1'b0, // value field is the operand
      srcRam = 1'b1  // operand read from RAM
   } operandSrcT;

   typedef struct packed {
      operandSrcT source; // bit 11
      opcodeT     opcode; // bits 10..8
      logic [7:0] value;  // immediate, or RAM address in the low bits
   } instrT;

   typedef logic [2:0] pcT;

   localparam int ProgramDepth = 8;

   typedef instrT programT [ProgramDepth];

   ////////////////////////////////////////
   // default ROM image
   ////////////////////////////////////////

   localparam programT bootProgram = '{
      '{srcImm, opMov,  8'h19}, // acc = 0x19
      '{srcRam, opNone, 8'h00}, // store slot, ram word 0
      '{srcImm, opMov,  8'h2d}, // acc = 0x2d
      '{srcRam, opNone, 8'h01}, // store slot, ram word 1
      '{srcRam, opMov,  8'h00}, // acc = ram[0]
      '{srcRam, opAdd,  8'h01}, // acc = ram[1] + acc
      '{srcRam, opNone, 8'h02}, // store slot, ram word 2
      '{srcRam, opShr,  8'h02}  // acc = ram[2] >> 1
   };

endpackage

// File: hw/coreTypesPkg.sv
package coreTypesPkg;

   import isaPkg::*;

   ////////////////////////////////////////
   // datapath
   ////////////////////////////////////////

   typedef logic [7:0] dataT;

   typedef logic [1:0] ramAddrT; // four RAM words

   typedef struct packed {
      logic carry;
      logic zero;
      logic negative;
      logic overflow; // signed, add and sub only
   } flagsT;

   ////////////////////////////////////////
   // stage to stage
   ////////////////////////////////////////

   // held in the instruction register between decode and execute
   typedef struct packed {
      operandSrcT source;
      opcodeT     opcode;
      dataT       value;
   } decodedT;

endpackage

// File: hw/fetchStage.sv
`timescale 1ns/100ps

module fetchStage
   import isaPkg::*;
#(
   parameter programT Program = bootProgram
)
(
   input  logic  clk,
   input  logic  reset,
   input  logic  fetch,
   output pcT    pc,
   output instrT instr
);

   ////////////////////////////////////////
   // program counter
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pc <= '0;
      end
      else if (fetch)
      begin
         pc <= pc + 3'd1; // wraps 7 -> 0
      end
      else
      begin
         pc <= '0; // fetch low restarts the program
      end
   end

   // ROM lookup, no latency
   assign instr = Program[pc];

   pcAdvance: assert property (
      @(posedge clk) disable iff (reset)
      fetch |=> (pc == pcT'($past(pc) + 3'd1))
   )
   else $error("pc did not advance on fetch");

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/100ps

module decodeStage
   import isaPkg::*;
   import coreTypesPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    decode,
   input  instrT   instr,
   output decodedT decoded
);

   localparam decodedT DecodedClear = '{srcImm, opAdd, 8'h00};

   // instruction register, loads on the decode strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         decoded <= DecodedClear;
      end
      else if (decode)
      begin
         decoded.source <= instr.source; // operand select
         decoded.opcode <= instr.opcode;
         decoded.value  <= instr.value;  // immediate or ram address
      end
   end

   // a pc advancing under a held register must not disturb it
   decodedHold: assert property (
      @(posedge clk) disable iff (reset)
      !decode |=> $stable(decoded)
   )
   else $error("instruction register changed without decode");

endmodule

// File: hw/dataMemory.sv
`timescale 1ns/100ps

module dataMemory
   import coreTypesPkg::*;
(
   input  logic    clk,
   input  logic    rw,        // 0 write, 1 read
   input  ramAddrT addr,
   input  dataT    writeData,
   output dataT    readData
);

   localparam int Depth = 4;

   dataT             mem [Depth];
   logic [Depth-1:0] wordSel; // one-hot word select

   ////////////////////////////////////////
   // address decoder
   ////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < Depth; i++)
      begin
         wordSel[i] = (addr == ramAddrT'(i));
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < Depth; i++)
      begin
         if (!rw && wordSel[i])
         begin
            mem[i] <= writeData; // acc stored
         end
      end
   end

   // read path gated by rw
   always_comb
   begin
      readData = '0;
      for (int i = 0; i < Depth; i++)
      begin
         if (rw && wordSel[i])
         begin
            readData = mem[i];
         end
      end
   end

   // rw is checked on every edge, addr whenever a write happens
   ramCtrlKnown: assert property (
      @(posedge clk) !$isunknown(rw) && (rw || !$isunknown(addr))
   )
   else $error("unknown RAM control");

endmodule

// File: hw/aluUnit.sv
`timescale 1ns/100ps

module aluUnit
   import isaPkg::*;
   import coreTypesPkg::*;
(
   input  dataT   operand,
   input  dataT   acc,
   input  opcodeT opcode,
   output dataT   result,
   output flagsT  flags
);

   logic [8:0] sum;  // carry in bit 8
   logic [8:0] diff; // operand + ~acc + 1

   assign sum  = {1'b0, operand} + {1'b0, acc};
   assign diff = {1'b0, operand} + {1'b0, ~acc} + 9'd1;

   ////////////////////////////////////////
   // function select
   ////////////////////////////////////////

   always_comb
   begin
      result        = '0;
      flags.carry    = 1'b0;
      flags.overflow = 1'b0;
      unique case (opcode)
         opAdd:
         begin
            result         = sum[7:0];
            flags.carry    = sum[8];
            flags.overflow = (operand[7] == acc[7]) && (sum[7] != operand[7]);
         end
         opSub:
         begin
            result         = diff[7:0];
            flags.carry    = diff[8]; // set when no borrow
            flags.overflow = (operand[7] != acc[7]) && (diff[7] != operand[7]);
         end
         opAnd:
         begin
            result = operand & acc;
         end
         opOr:
         begin
            result = operand | acc;
         end
         opMov:
         begin
            result = operand;
         end
         opShl:
         begin
            result = {operand[6:0], 1'b0};
         end
         opShr:
         begin
            result = {1'b0, operand[7:1]};
         end
         opNone:
         begin
            result = '0;
         end
      endcase
      flags.zero     = (result == '0);
      flags.negative = result[7];
   end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/100ps

module executeStage
   import isaPkg::*;
   import coreTypesPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    ex,
   input  decodedT decoded,
   input  dataT    readData,
   output dataT    acc,
   output flagsT   flags
);

   dataT operand;
   dataT aluResult;

   // immediate or RAM word
   assign operand = (decoded.source == srcRam) ? readData : decoded.value;

   aluUnit alu
   (
      .operand (operand),
      .acc     (acc),
      .opcode  (decoded.opcode),
      .result  (aluResult),
      .flags   (flags)
   );

   ////////////////////////////////////////
   // accumulator
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         acc <= '0;
      end
      else if (ex)
      begin
         acc <= aluResult;
      end
   end

   accHold: assert property (
      @(posedge clk) disable iff (reset)
      !ex |=> $stable(acc)
   )
   else $error("accumulator changed without ex");

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/100ps

module cpuTop
   import isaPkg::*;
   import coreTypesPkg::*;
#(
   parameter programT Program = bootProgram
)
(
   input  logic   clk,
   input  logic   reset,
   input  logic   fetch,
   input  logic   decode,
   input  logic   ex,
   input  logic   rw,
   output pcT     pc,
   output opcodeT op,
   output dataT   acc,
   output flagsT  flags
);

   instrT   instr;
   decodedT decoded;
   dataT    readData;
   ramAddrT ramAddr;

   ////////////////////////////////////////
   // stages
   ////////////////////////////////////////

   fetchStage #(
      .Program (Program)
   ) fetchU
   (
      .clk   (clk),
      .reset (reset),
      .fetch (fetch),
      .pc    (pc),
      .instr (instr)
   );

   decodeStage decodeU
   (
      .clk     (clk),
      .reset   (reset),
      .decode  (decode),
      .instr   (instr),
      .decoded (decoded)
   );

   executeStage executeU
   (
      .clk      (clk),
      .reset    (reset),
      .ex       (ex),
      .decoded  (decoded),
      .readData (readData),
      .acc      (acc),
      .flags    (flags)
   );

   assign ramAddr = decoded.value[1:0]; // low value bits pick the word

   dataMemory ramU
   (
      .clk       (clk),
      .rw        (rw),
      .addr      (ramAddr),
      .writeData (acc),
      .readData  (readData)
   );

   assign op = decoded.opcode;

endmodule

// File: sim/tbClock.sv
`timescale 1ns/100ps

module tbClock
#(
   parameter int HalfPeriod  = 5,
   parameter int ResetCycles = 16
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #HalfPeriod clk = ~clk; // 10 ns period
      end
   end

   // reset drops just after an edge, like the other inputs
   initial
   begin
      reset = 1'b1;
      repeat (ResetCycles) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// File: sim/cpuTb.sv
`timescale 1ns/100ps

module cpuTb
   import isaPkg::*;
   import coreTypesPkg::*;
();

   localparam programT testProgram = '{
      '{srcImm, opAdd, 8'h7f}, // ram word 3 when used as an address
      '{srcImm, opSub, 8'h10},
      '{srcImm, opAnd, 8'hf0},
      '{srcImm, opOr,  8'h0f},
      '{srcImm, opShl, 8'hc1}, // top bit falls off
      '{srcImm, opShr, 8'h1e},
      '{srcRam, opMov, 8'h01}, // ram word 1
      '{srcRam, opAdd, 8'h02}  // ram word 2
   };

   // worst-case cycles: reset, pc count, 22 instruction runs, hold
   localparam int StepLen    = 10;
   localparam int TestCycles = 17 + 13 + 22 * StepLen + 14;
   localparam int CycleLimit = 2 * TestCycles;

   logic   clk;
   logic   reset;
   logic   fetch;
   logic   decode;
   logic   ex;
   logic   rw;
   pcT     pc;
   opcodeT op;
   dataT   acc;
   flagsT  flags;

   dataT   expAcc;
   dataT   expRam [4];
   flagsT  seenFlags; // flag bits the DUT has raised
   int     cycles     = 0;
   int     errors     = 0;
   int     checks     = 0;
   int     testErrors = 0;
   int     testCount  = 0;
   string  testName;

   tbClock clockGen
   (
      .clk   (clk),
      .reset (reset)
   );

   cpuTop #(
      .Program (testProgram)
   ) dut
   (
      .clk    (clk),
      .reset  (reset),
      .fetch  (fetch),
      .decode (decode),
      .ex     (ex),
      .rw     (rw),
      .pc     (pc),
      .op     (op),
      .acc    (acc),
      .flags  (flags)
   );

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   function automatic dataT modelResult(opcodeT opcode, dataT operand, dataT accIn);
      dataT r;
      case (opcode)
         opAdd:   r = operand + accIn;
         opSub:   r = operand - accIn; // operand first
         opAnd:   r = operand & accIn;
         opOr:    r = operand | accIn;
         opMov:   r = operand;
         opShl:   r = operand << 1;
         opShr:   r = operand >> 1;
         default: r = 8'h00;
      endcase
      return r;
   endfunction

   function automatic flagsT modelFlags(opcodeT opcode, dataT operand, dataT accIn);
      flagsT f;
      dataT  r;
      int    wide; // exact signed result
      r = modelResult(opcode, operand, accIn);
      f = '0;
      if (opcode == opAdd)
      begin
         wide       = int'($signed(operand)) + int'($signed(accIn));
         f.carry    = (int'(operand) + int'(accIn)) > 255;
         f.overflow = (wide > 127) || (wide < -128);
      end
      else if (opcode == opSub)
      begin
         wide       = int'($signed(operand)) - int'($signed(accIn));
         f.carry    = operand >= accIn; // no borrow
         f.overflow = (wide > 127) || (wide < -128);
      end
      f.zero     = (r == 8'h00);
      f.negative = r[7];
      return f;
   endfunction

   function automatic dataT operandOf(instrT instr);
      if (instr.source == srcRam)
      begin
         return expRam[instr.value[1:0]];
      end
      return instr.value;
   endfunction

   ////////////////////////////////////////
   // checks and reporting
   ////////////////////////////////////////

   task automatic noteMismatch();
      errors++;
      testErrors++;
   endtask

   task automatic checkData(string name, dataT got, dataT exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         noteMismatch();
      end
   endtask

   task automatic checkFlags(string name, flagsT got, flagsT exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         noteMismatch();
      end
   endtask

   task automatic checkOp(string name, opcodeT got, opcodeT exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         noteMismatch();
      end
   endtask

   task automatic checkPc(string name, pcT got, pcT exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         noteMismatch();
      end
   endtask

   task automatic startTest(string name);
      testName   = name;
      testErrors = 0;
      testCount++;
   endtask

   task automatic finishTest();
      if (testErrors == 0)
      begin
         $display("test %s: passed", testName);
      end
      else
      begin
         $display("test %s: %0d mismatches", testName, testErrors);
      end
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   task automatic tick();
      @(posedge clk);
      #1; // inputs change just after the edge
   endtask

   // restart the pc and count up to the wanted word
   task automatic stepTo(pcT target);
      fetch = 1'b0;
      tick();
      fetch = 1'b1;
      repeat (int'(target))
      begin
         tick();
      end
      fetch = 1'b0; // pc returns to 0 on the next edge
      checkPc("pc", pc, target);
   endtask

   task automatic decodeAt(pcT addr);
      stepTo(addr);
      decode = 1'b1;
      tick();
      decode = 1'b0;
      checkOp("op", op, testProgram[addr].opcode);
   endtask

   task automatic runInstr(pcT addr);
      instrT instr;
      dataT  operand;
      flagsT expFlags;
      instr    = testProgram[addr];
      operand  = operandOf(instr);
      expFlags = modelFlags(instr.opcode, operand, expAcc);
      decodeAt(addr);
      checkFlags("flags", flags, expFlags); // before ex
      seenFlags = seenFlags | flags;
      ex = 1'b1;
      tick();
      ex = 1'b0;
      expAcc = modelResult(instr.opcode, operand, expAcc);
      checkData("acc", acc, expAcc);
   endtask

   // one edge with rw low stores acc in the word the value points at
   task automatic storeAcc(pcT addr);
      decodeAt(addr);
      rw = 1'b0;
      tick();
      rw = 1'b1;
      expRam[testProgram[addr].value[1:0]] = expAcc;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic testReset();
      startTest("reset");
      checkPc("pc", pc, 3'd0);
      checkOp("op", op, opAdd);
      checkData("acc", acc, 8'h00);
      finishTest();
   endtask

   task automatic testPcCount();
      startTest("pc count");
      fetch = 1'b0;
      tick();
      fetch = 1'b1;
      for (int i = 1; i <= 11; i++)
      begin
         tick();
         checkPc("pc", pc, pcT'(i)); // wraps after 7
      end
      fetch = 1'b0;
      tick();
      checkPc("pc", pc, 3'd0);
      finishTest();
   endtask

   task automatic testImmediate();
      startTest("immediate");
      for (int a = 0; a < 6; a++)
      begin
         runInstr(pcT'(a));
      end
      finishTest();
   endtask

   task automatic testFlags();
      pcT order [10] = '{3'd5, 3'd2, 3'd1, 3'd1, 3'd0, 3'd0, 3'd0, 3'd4, 3'd1, 3'd3};
      startTest("flags");
      seenFlags = '0;
      foreach (order[i])
      begin
         runInstr(order[i]);
      end
      if (seenFlags !== 4'b1111)
      begin
         $display("DUT never raised some of the flags, seen %b", seenFlags);
         noteMismatch();
      end
      finishTest();
   endtask

   task automatic testRam();
      startTest("ram");
      runInstr(3'd5);
      storeAcc(3'd6); // word 1
      runInstr(3'd4);
      storeAcc(3'd7); // word 2
      runInstr(3'd6); // mov from word 1
      runInstr(3'd7); // add word 2
      finishTest();
   endtask

   task automatic testHold();
      startTest("hold");
      decodeAt(3'd1);
      repeat (4)
      begin
         tick();
         checkData("acc", acc, expAcc);
      end
      fetch = 1'b1;
      for (int i = 1; i <= 6; i++)
      begin
         tick();
         checkPc("pc", pc, pcT'(i));
         checkOp("op", op, opSub); // register keeps word 1
      end
      fetch = 1'b0;
      tick();
      finishTest();
   endtask

   ////////////////////////////////////////
   // run control
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > CycleLimit)
      begin
         $display("timeout: tests still running after %0d cycles", cycles);
         $display("Errors found");
         $finish;
      end
   end

   initial
   begin
      fetch  = 1'b0;
      decode = 1'b0;
      ex     = 1'b0;
      rw     = 1'b1; // read, nothing written
      expAcc = 8'h00;
      @(negedge reset);
      tick();
      testReset();
      testPcCount();
      testImmediate();
      testFlags();
      testRam();
      testHold();
      $display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
      if (errors == 0)
      begin
         $display("No errors");
      end
      else
      begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: vlog.f
hw/isaPkg.sv
hw/coreTypesPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/dataMemory.sv
hw/aluUnit.sv
hw/executeStage.sv
hw/cpuTop.sv
sim/tbClock.sv
sim/cpuTb.sv

// File: Makefile
SIM       = verilator
TOP       = cpuTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/100ps
PASS      = No errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR)
